//--- fsp_geom_pkg.sv
package fsp_geom_pkg;

  localparam int ROW_W     = 12;  // camera row bits
  localparam int COL_W     = 12;  // camera column bits
  localparam int FSP_WIDTH = 6;   // coefficients per footprint row
  localparam int FSP_ROW   = 1;   // row of this summer inside the footprint

  // index of a slot or of a column offset inside one footprint row
  localparam int OFS_W = $clog2(FSP_WIDTH);

  // trace row plus FSP_ROW, one extra bit so the top row does not wrap
  localparam int ADJ_ROW_W = ROW_W + 1;

  // configured column minus trace column, signed
  localparam int SOFS_W = COL_W + 1;

  typedef struct packed {
    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
  } pixel_coord_t;

endpackage

//--- fsp_data_pkg.sv
package fsp_data_pkg;

  localparam int SAMPLE_W = 16;  // signed trace / coefficient
  localparam int ACC_W    = 32;  // signed sum, wraps mod 2^32

  typedef logic [SAMPLE_W-1:0] sample_t;

  // one value per footprint column
  typedef sample_t [fsp_geom_pkg::FSP_WIDTH-1:0] sample_row_t;

  typedef struct packed {
    logic [ACC_W-1:0] grn;
    logic [ACC_W-1:0] red;
  } color_pair_t;

  // one camera sample as it streams in
  typedef struct packed {
    fsp_geom_pkg::pixel_coord_t coord;
    sample_t                    grn_trace;
    sample_t                    red_trace;
    sample_row_t                grn_fsp;    // coefficient per column offset
    sample_row_t                red_fsp;
  } trace_sample_t;

  // operands handed to the adder tree, slot i pairs trace[i] with coef[i]
  typedef struct packed {
    color_pair_t init_value;
    sample_row_t grn_trace;
    sample_row_t grn_coef;
    sample_row_t red_trace;
    sample_row_t red_coef;
  } product_set_t;

  typedef enum logic [1:0] {
    FREE,        // waiting for init
    COLLECTING,  // classifying samples
    FINISHING,   // start cycle
    WAITING      // result held, waiting for release
  } capture_state_t;

endpackage

//--- trace_window_capture.sv
`timescale 1ns/1ps

module trace_window_capture (
  input  logic                        CLK,
  input  logic                        RESET,
  input  logic                        init,
  input  fsp_geom_pkg::pixel_coord_t  config_coord,
  input  fsp_data_pkg::color_pair_t   config_initial,
  input  logic                        trace_valid,
  input  fsp_data_pkg::trace_sample_t trace,
  input  logic                        release_pulse,
  output logic                        available,
  output logic                        start,
  output fsp_data_pkg::product_set_t  products_in
);

  fsp_data_pkg::capture_state_t state;
  fsp_geom_pkg::pixel_coord_t   target;
  fsp_data_pkg::color_pair_t    init_value;
  fsp_data_pkg::trace_sample_t  trace_d;
  logic                         trace_valid_d;
  logic [fsp_geom_pkg::ADJ_ROW_W-1:0]     adj_row;
  logic signed [fsp_geom_pkg::SOFS_W-1:0] col_ofs;
  logic [fsp_geom_pkg::ADJ_ROW_W-1:0]     target_row;
  logic [fsp_geom_pkg::OFS_W-1:0]         n_stored;
  logic [fsp_geom_pkg::OFS_W-1:0]         fsp_idx;
  fsp_data_pkg::sample_row_t    grn_trace_s;
  fsp_data_pkg::sample_row_t    grn_coef_s;
  fsp_data_pkg::sample_row_t    red_trace_s;
  fsp_data_pkg::sample_row_t    red_coef_s;
  logic                         take_init;
  logic                         rows_equal;
  logic                         is_before;
  logic                         is_overlap;

  assign take_init = (state == fsp_data_pkg::FREE) && init;
  assign available = state == fsp_data_pkg::FREE;
  assign start     = state == fsp_data_pkg::FINISHING;  // one cycle per request

  // pixel target and start value of the sum
  always_ff @(posedge CLK) begin
    if (take_init) begin
      target     <= config_coord;
      init_value <= config_initial;
    end
  end

  // registered copy of the sample, classified on the next cycle
  always_ff @(posedge CLK) begin
    trace_d <= trace;
    adj_row <= {1'b0, trace.coord.row} + fsp_geom_pkg::ADJ_ROW_W'(fsp_geom_pkg::FSP_ROW);
    col_ofs <= $signed({1'b0, target.col}) - $signed({1'b0, trace.coord.col});
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      trace_valid_d <= 1'b0;
    end else begin
      trace_valid_d <= trace_valid;
    end
  end

  assign target_row = {1'b0, target.row};
  assign rows_equal = adj_row == target_row;
  assign is_before  = (adj_row < target_row)
                    || (rows_equal && col_ofs >= fsp_geom_pkg::FSP_WIDTH);
  assign is_overlap = rows_equal && col_ofs >= 0 && col_ofs < fsp_geom_pkg::FSP_WIDTH;
  assign fsp_idx    = col_ofs[fsp_geom_pkg::OFS_W-1:0];  // only used on overlap

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state       <= fsp_data_pkg::FREE;
      n_stored    <= '0;
      grn_trace_s <= '0;  // zero slots give a zero product
      grn_coef_s  <= '0;
      red_trace_s <= '0;
      red_coef_s  <= '0;
    end else begin
      case (state)
        fsp_data_pkg::FREE: begin
          if (take_init) state <= fsp_data_pkg::COLLECTING;
        end
        fsp_data_pkg::COLLECTING: begin
          if (trace_valid_d && !is_before) begin
            if (is_overlap) begin
              grn_trace_s[n_stored] <= trace_d.grn_trace;
              grn_coef_s[n_stored]  <= trace_d.grn_fsp[fsp_idx];
              red_trace_s[n_stored] <= trace_d.red_trace;
              red_coef_s[n_stored]  <= trace_d.red_fsp[fsp_idx];
              n_stored              <= n_stored + 1'b1;
              if (n_stored == fsp_geom_pkg::OFS_W'(fsp_geom_pkg::FSP_WIDTH - 1)) begin
                state <= fsp_data_pkg::FINISHING;  // all slots full
              end
            end else begin
              state <= fsp_data_pkg::FINISHING;  // after sample closes the row
            end
          end
        end
        fsp_data_pkg::FINISHING: begin
          state <= fsp_data_pkg::WAITING;
        end
        fsp_data_pkg::WAITING: begin
          if (release_pulse) begin
            n_stored    <= '0;
            grn_trace_s <= '0;
            grn_coef_s  <= '0;
            red_trace_s <= '0;
            red_coef_s  <= '0;
            state       <= fsp_data_pkg::FREE;
          end
        end
        default: state <= fsp_data_pkg::FREE;
      endcase
    end
  end

  assign products_in = '{init_value: init_value,
                         grn_trace:  grn_trace_s,
                         grn_coef:   grn_coef_s,
                         red_trace:  red_trace_s,
                         red_coef:   red_coef_s};

endmodule

//--- dot_product_tree.sv
`timescale 1ns/1ps

module dot_product_tree (
  input  logic                       CLK,
  input  logic                       RESET,
  input  logic                       start,
  input  fsp_data_pkg::product_set_t products_in,
  output logic                       sum_valid,
  output fsp_data_pkg::color_pair_t  sum
);

  // index 0 is green, index 1 is red
  fsp_data_pkg::sample_row_t trace_sel [2];
  fsp_data_pkg::sample_row_t coef_sel  [2];
  logic [fsp_data_pkg::ACC_W-1:0] init_sel [2];

  logic signed [fsp_data_pkg::ACC_W-1:0] prod [2][fsp_geom_pkg::FSP_WIDTH];
  logic [fsp_data_pkg::ACC_W-1:0] init_d   [2];
  logic [fsp_data_pkg::ACC_W-1:0] pair_sum [2][4];
  logic [fsp_data_pkg::ACC_W-1:0] half_sum [2][2];
  logic [fsp_data_pkg::ACC_W-1:0] total    [2];
  logic prod_valid;
  logic pair_valid;
  logic half_valid;

  always_comb begin
    trace_sel[0] = products_in.grn_trace;
    trace_sel[1] = products_in.red_trace;
    coef_sel[0]  = products_in.grn_coef;
    coef_sel[1]  = products_in.red_coef;
    init_sel[0]  = products_in.init_value.grn;
    init_sel[1]  = products_in.init_value.red;
  end

  // multiply, four pair adds, two adds, final add
  always_ff @(posedge CLK) begin
    for (int c = 0; c < 2; c++) begin
      for (int i = 0; i < fsp_geom_pkg::FSP_WIDTH; i++) begin
        prod[c][i] <= $signed(trace_sel[c][i]) * $signed(coef_sel[c][i]);
      end
      init_d[c] <= init_sel[c];  // travels with the products

      pair_sum[c][0] <= init_d[c] + prod[c][0];
      pair_sum[c][1] <= prod[c][1] + prod[c][2];
      pair_sum[c][2] <= prod[c][3] + prod[c][4];
      pair_sum[c][3] <= prod[c][5];  // odd one out

      half_sum[c][0] <= pair_sum[c][0] + pair_sum[c][1];
      half_sum[c][1] <= pair_sum[c][2] + pair_sum[c][3];

      total[c] <= half_sum[c][0] + half_sum[c][1];
    end
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      prod_valid <= 1'b0;
      pair_valid <= 1'b0;
      half_valid <= 1'b0;
      sum_valid  <= 1'b0;
    end else begin
      prod_valid <= start;
      pair_valid <= prod_valid;
      half_valid <= pair_valid;
      sum_valid  <= half_valid;
    end
  end

  assign sum.grn = total[0];
  assign sum.red = total[1];

endmodule

//--- row_result_hold.sv
`timescale 1ns/1ps

module row_result_hold (
  input  logic                      CLK,
  input  logic                      RESET,
  input  logic                      sum_valid,
  input  fsp_data_pkg::color_pair_t sum,
  input  logic                      sum_ack,
  output logic                      done,
  output fsp_data_pkg::color_pair_t result,
  output logic                      release_pulse
);

  logic ack_taken;

  assign ack_taken = done && sum_ack;  // ack while idle is dropped

  always_ff @(posedge CLK) begin
    if (sum_valid) result <= sum;  // held until the next row
  end

  always_ff @(posedge CLK) begin
    if (RESET) begin
      done          <= 1'b0;
      release_pulse <= 1'b0;
    end else begin
      release_pulse <= ack_taken;  // frees the capture side
      if (sum_valid) begin
        done <= 1'b1;
      end else if (ack_taken) begin
        done <= 1'b0;
      end
    end
  end

endmodule

//--- camera_trace_row_summer.sv
`timescale 1ns/1ps

module camera_trace_row_summer (
  input  logic                        CLK,
  input  logic                        RESET,
  input  logic                        init,
  input  fsp_geom_pkg::pixel_coord_t  config_coord,
  input  fsp_data_pkg::color_pair_t   config_initial,
  input  logic                        trace_valid,
  input  fsp_data_pkg::trace_sample_t trace,
  input  logic                        sum_ack,
  output logic                        available,
  output logic                        done,
  output fsp_data_pkg::color_pair_t   result
);

  logic                       start;
  fsp_data_pkg::product_set_t products_in;
  logic                       sum_valid;
  fsp_data_pkg::color_pair_t  sum;
  logic                       release_pulse;

  trace_window_capture u_capture (
    .CLK           (CLK),
    .RESET         (RESET),
    .init          (init),
    .config_coord  (config_coord),
    .config_initial(config_initial),
    .trace_valid   (trace_valid),
    .trace         (trace),
    .release_pulse (release_pulse),
    .available     (available),
    .start         (start),
    .products_in   (products_in)
  );

  dot_product_tree u_tree (
    .CLK        (CLK),
    .RESET      (RESET),
    .start      (start),
    .products_in(products_in),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  row_result_hold u_hold (
    .CLK          (CLK),
    .RESET        (RESET),
    .sum_valid    (sum_valid),
    .sum          (sum),
    .sum_ack      (sum_ack),
    .done         (done),
    .result       (result),
    .release_pulse(release_pulse)
  );

endmodule

//--- row_sum_checker.sv
`timescale 1ns/1ps

module row_sum_checker (
  input  logic                      CLK,
  input  logic                      RESET,
  input  logic                      done,
  input  fsp_data_pkg::color_pair_t result,
  input  fsp_data_pkg::color_pair_t expected,
  output int                        mismatches,
  output int                        checked
);

  logic                      done_q;
  fsp_data_pkg::color_pair_t held;  // result seen on the rising edge of done

  task automatic compare_word(input string name, input logic [31:0] exp,
                              input logic [31:0] got);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s: expected %h, got %h", name, exp, got);
    end
  endtask

  always @(negedge CLK) begin
    if (RESET) begin
      mismatches = 0;
      checked    = 0;
      done_q     = 1'b0;
    end else begin
      if (done && !done_q) begin
        checked++;
        held = result;
        compare_word("result.grn", expected.grn, result.grn);
        compare_word("result.red", expected.red, result.red);
      end else if (done) begin
        compare_word("result.grn while held", held.grn, result.grn);  // must not move
        compare_word("result.red while held", held.red, result.red);
      end
      done_q = done;
    end
  end

endmodule

//--- row_sum_props.sv
`timescale 1ns/1ps

module row_sum_props (
  input logic CLK,
  input logic RESET,
  input logic done,
  input logic sum_ack,
  input logic start,
  input logic available
);

  logic started;  // a start was issued for the current request

  always_ff @(posedge CLK) begin
    if (RESET || available) begin
      started <= 1'b0;
    end else if (start) begin
      started <= 1'b1;
    end
  end

  done_waits_for_ack: assert property (@(posedge CLK) disable iff (RESET)
    $fell(done) |-> $past(sum_ack)) else $error("done dropped without sum_ack");

  single_start: assert property (@(posedge CLK) disable iff (RESET)
    start |-> !started) else $error("second start within one request");

  free_or_done: assert property (@(posedge CLK) disable iff (RESET)
    !(available && done)) else $error("available and done high together");

endmodule

// top level is where the capture and hold signals meet
bind camera_trace_row_summer row_sum_props u_props (
  .CLK      (CLK),
  .RESET    (RESET),
  .done     (done),
  .sum_ack  (sum_ack),
  .start    (start),
  .available(available)
);

//--- tb_camera_trace_row_summer.sv
`timescale 1ns/1ps

module tb_camera_trace_row_summer;

  localparam int WAIT_LIMIT = 100;  // cycles

  logic CLK = 1'b0;
  logic RESET;
  logic init;
  logic trace_valid;
  logic sum_ack;
  logic available;
  logic done;
  fsp_geom_pkg::pixel_coord_t  config_coord;
  fsp_data_pkg::color_pair_t   config_initial;
  fsp_data_pkg::trace_sample_t trace;
  fsp_data_pkg::color_pair_t   result;
  fsp_data_pkg::color_pair_t   expected;
  fsp_data_pkg::trace_sample_t row_q [$];  // samples of the next row
  int cyc = 0;
  int errors = 0;
  int n_rows = 0;
  bit timed_out = 1'b0;
  int mismatches;
  int checked;

  always #2 CLK = ~CLK;
  always @(posedge CLK) cyc <= cyc + 1;

  camera_trace_row_summer u_dut (.*);
  row_sum_checker u_checker (.*);

  // expected sums by the overlap rule
  // last returns the index of the sample that closes the row
  function automatic fsp_data_pkg::color_pair_t row_projection(
    input fsp_geom_pkg::pixel_coord_t px, input fsp_data_pkg::color_pair_t init_val,
    input fsp_data_pkg::trace_sample_t s [$], output int last);
    fsp_data_pkg::color_pair_t acc;
    int adj;
    int ofs;
    int n_ov;
    acc  = init_val;
    n_ov = 0;
    last = -1;
    foreach (s[i]) begin
      adj = int'(s[i].coord.row) + fsp_geom_pkg::FSP_ROW;
      ofs = int'(px.col) - int'(s[i].coord.col);
      if (last < 0 && adj == int'(px.row) && ofs >= 0 && ofs < fsp_geom_pkg::FSP_WIDTH) begin
        acc.grn += 32'(int'($signed(s[i].grn_trace)) * int'($signed(s[i].grn_fsp[ofs])));
        acc.red += 32'(int'($signed(s[i].red_trace)) * int'($signed(s[i].red_fsp[ofs])));
        n_ov++;
        if (n_ov == fsp_geom_pkg::FSP_WIDTH) last = i;  // slots full
      end else if (last < 0 && (adj > int'(px.row) || (adj == int'(px.row) && ofs < 0))) begin
        last = i;
      end
    end
    return acc;
  endfunction

  // kind 0 before, 1 overlap, 2 after
  function automatic fsp_data_pkg::trace_sample_t make_sample(
    input fsp_geom_pkg::pixel_coord_t px, input int kind);
    fsp_data_pkg::trace_sample_t s;
    logic [255:0] bits;
    int row;
    int col;
    bits = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom};
    s    = bits[$bits(s)-1:0];
    row  = int'(px.row) - fsp_geom_pkg::FSP_ROW;  // footprint row lines up
    col  = int'(px.col) - int'($urandom % fsp_geom_pkg::FSP_WIDTH);
    if (kind == 0) begin
      if ($urandom % 2) row = row - 1 - int'($urandom % 3);
      else col = int'(px.col) - fsp_geom_pkg::FSP_WIDTH - int'($urandom % 8);
    end else if (kind == 2) begin
      if ($urandom % 2) row = row + 1 + int'($urandom % 3);
      else col = int'(px.col) + 1 + int'($urandom % 8);
    end
    s.coord.row = fsp_geom_pkg::ROW_W'(row);
    s.coord.col = fsp_geom_pkg::COL_W'(col);
    return s;
  endfunction

  task automatic build_row(input fsp_geom_pkg::pixel_coord_t px, input int n_over,
                           input int n_after);
    row_q.delete();
    for (int i = 0; i < n_over; i++) begin
      if ($urandom % 2) row_q.push_back(make_sample(px, 0));
      row_q.push_back(make_sample(px, 1));
    end
    row_q.push_back(make_sample(px, 0));
    repeat (n_after) row_q.push_back(make_sample(px, 2));
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic finish_run();
    $display("rows %0d, result mismatches %0d, other errors %0d", n_rows, mismatches, errors);
    if (errors == 0 && mismatches == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string why);
    errors++;
    timed_out = 1'b1;
    $display("ERROR: %s", why);
  endtask

  task automatic run_request(input fsp_geom_pkg::pixel_coord_t px,
                             input fsp_data_pkg::color_pair_t iv, input int hold, input bit junk);
    int accept [$];
    int last;
    int n;
    if (timed_out) return;
    n = 0;
    while (!available) begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT) begin
        report_timeout("available stayed low, capture side never freed");
        return;
      end
    end
    config_coord   = px;
    config_initial = iv;
    init           = 1'b1;
    @(negedge CLK);
    init = 1'b0;
    check_value("available", 32'd0, 32'(available));
    expected = row_projection(px, iv, row_q, last);
    foreach (row_q[i]) begin
      trace       = row_q[i];
      trace_valid = 1'b1;
      accept.push_back(cyc + 1);  // taken on the coming rising edge
      @(negedge CLK);
    end
    trace_valid = 1'b0;
    n = 0;
    while (!done) begin
      @(negedge CLK);
      n++;
      if (n > WAIT_LIMIT) begin
        report_timeout("done never rose for the row");
        return;
      end
    end
    check_value("done latency", 32'd6, 32'(cyc - accept[last]));
    repeat (hold) begin
      trace       = make_sample(px, 1);  // overlap data that must be ignored
      trace_valid = junk;
      @(negedge CLK);
    end
    trace_valid = 1'b0;
    check_value("done", 32'd1, 32'(done));
    sum_ack = 1'b1;
    @(negedge CLK);
    sum_ack = 1'b0;
    check_value("done", 32'd0, 32'(done));
    n_rows++;
  endtask

  initial begin
    fsp_geom_pkg::pixel_coord_t px;
    fsp_data_pkg::color_pair_t  iv;
    int n_over;
    int r;
    void'($urandom(18));
    RESET          = 1'b1;
    init           = 1'b0;
    config_coord   = '0;
    config_initial = '0;
    trace_valid    = 1'b0;
    trace          = '0;
    sum_ack        = 1'b0;
    expected       = '0;
    repeat (2) @(negedge CLK);
    RESET = 1'b0;
    check_value("available", 32'd1, 32'(available));
    check_value("done", 32'd0, 32'(done));
    px = '{row: 12'd300, col: 12'd100};
    build_row(px, 6, 2);  // full row with trailing samples
    run_request(px, '{grn: 32'h7fff_fff0, red: 32'hffff_fff8}, 2, 1'b0);
    build_row(px, 3, 1);  // closed early by an after sample
    run_request(px, '{grn: 32'd1000, red: 32'hffff_fffb}, 0, 1'b0);
    build_row(px, 0, 2);
    run_request(px, '{grn: 32'h1234_5678, red: 32'h8765_4321}, 1, 1'b0);
    build_row(px, 4, 1);
    run_request(px, '{grn: 32'd7, red: 32'd9}, 40, 1'b1);  // late ack with samples in between
    for (r = 0; r < 50; r++) begin
      px.row = fsp_geom_pkg::ROW_W'(5 + $urandom % 3990);
      px.col = fsp_geom_pkg::COL_W'(20 + $urandom % 3980);
      iv     = {$urandom, $urandom};
      n_over = int'($urandom % 7);
      build_row(px, n_over, (n_over == 6) ? int'($urandom % 3) : 1 + int'($urandom % 2));
      run_request(px, iv, int'($urandom % 4), 1'b1);
    end
    if (checked != n_rows) begin
      errors++;
      $display("checker compared %0d results for %0d rows", checked, n_rows);
    end
    finish_run();
  end

endmodule

//--- verilog.f
fsp_geom_pkg.sv
fsp_data_pkg.sv
trace_window_capture.sv
dot_product_tree.sv
row_result_hold.sv
camera_trace_row_summer.sv
row_sum_checker.sv
row_sum_props.sv
tb_camera_trace_row_summer.sv

//--- run_verilator.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module tb_camera_trace_row_summer -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
if grep -q "Test FAILED" sim.log; then
  exit 1
fi
